// ==== cart_bus_pkg.sv ====
/* Cartridge bus definitions */

package cart_bus_pkg;

	// Bus widths
	localparam int CPU_ADDR_W = 16;                    // CPU address bus
	localparam int PPU_ADDR_W = 14;                    // PPU address bus
	localparam int MEM_ADDR_W = 22;                    // Mapped memory address

	// Page offsets
	localparam int PRG_PAGE_W = 13;                    // 8 KB PRG page
	localparam int CHR_PAGE_W = 10;                    // 1 KB CHR page

	// Upper address bits in mapped memory
	localparam logic [8:0] PRG_RAM_PREFIX = 9'b111100000; // PRG RAM region
	localparam logic [3:0] CHR_ROM_PREFIX = 4'b1000;      // CHR region

	// CPU A15..A13 of the $6000-$7FFF window
	localparam logic [2:0] RAM_REGION = 3'b011;

endpackage

// ==== mmc3_regs_pkg.sv ====
/* MMC3 register map */

package mmc3_regs_pkg;

	// Bank number widths
	localparam int PRG_BANK_W = 6;                     // 8 KB PRG banks, up to 512 KB
	localparam int CHR_BANK_W = 8;                     // 1 KB CHR banks, up to 256 KB
	localparam int BANK_IDX_W = 3;                     // R0..R7

	// Hard-wired PRG banks
	localparam logic [PRG_BANK_W-1:0] PRG_BANK_LAST        = '1;            // Always at $E000
	localparam logic [PRG_BANK_W-1:0] PRG_BANK_SECOND_LAST = {{(PRG_BANK_W-1){1'b1}}, 1'b0};

	// A12 low time needed before the next edge counts
	localparam logic [3:0] A12_COOLDOWN = 4'd15;       // In CPU cycles

	// Bank register indices
	localparam logic [BANK_IDX_W-1:0] REG_R0 = 3'd0;   // 2 KB CHR
	localparam logic [BANK_IDX_W-1:0] REG_R1 = 3'd1;   // 2 KB CHR
	localparam logic [BANK_IDX_W-1:0] REG_R2 = 3'd2;   // 1 KB CHR
	localparam logic [BANK_IDX_W-1:0] REG_R3 = 3'd3;   // 1 KB CHR
	localparam logic [BANK_IDX_W-1:0] REG_R4 = 3'd4;   // 1 KB CHR
	localparam logic [BANK_IDX_W-1:0] REG_R5 = 3'd5;   // 1 KB CHR
	localparam logic [BANK_IDX_W-1:0] REG_R6 = 3'd6;   // 8 KB PRG
	localparam logic [BANK_IDX_W-1:0] REG_R7 = 3'd7;   // 8 KB PRG

	// CPU write byte, decoded as bank select at $8000 and RAM control at $A001
	typedef union packed {
		struct packed {
			logic                  chr_invert;     // Swap CHR 4 KB halves
			logic                  prg_mode;       // Swap $8000 and $C000 slots
			logic [2:0]            unused;
			logic [BANK_IDX_W-1:0] bank_idx;       // Target of next bank data write
		} bank_select;
		struct packed {
			logic                  ram_en;         // PRG RAM chip enable
			logic                  ram_wp;         // Deny writes
			logic [5:0]            unused;
		} ram_ctrl;
	} mmc3_wdata_u;

endpackage

// ==== mmc3_reg_ctrl.sv ====
/* MMC3 register control */

`timescale 1ns/1ps
`default_nettype none

module mmc3_reg_ctrl
	import cart_bus_pkg::*;
	import mmc3_regs_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire                   ce_i,            // One clock per CPU cycle
	input  wire [CPU_ADDR_W-1:0]  prg_ain_i,
	input  wire                   prg_write_i,
	input  wire [7:0]             prg_din_i,
	output logic [PRG_BANK_W-1:0] prg_bank6_o,
	output logic [PRG_BANK_W-1:0] prg_bank7_o,
	output logic [CHR_BANK_W-1:0] chr_bank_r0_o,
	output logic [CHR_BANK_W-1:0] chr_bank_r1_o,
	output logic [CHR_BANK_W-1:0] chr_bank_r2_o,
	output logic [CHR_BANK_W-1:0] chr_bank_r3_o,
	output logic [CHR_BANK_W-1:0] chr_bank_r4_o,
	output logic [CHR_BANK_W-1:0] chr_bank_r5_o,
	output logic                  prg_mode_o,
	output logic                  chr_invert_o,
	output logic                  mirroring_o,     // 0 vertical, 1 horizontal
	output logic                  ram_en_o,
	output logic                  ram_wp_o,
	output logic [7:0]            irq_data_o,
	output logic                  irq_latch_wr_o,
	output logic                  irq_reload_o,
	output logic                  irq_disable_o,
	output logic                  irq_enable_o
);

	mmc3_wdata_u           wdata;                  // Write byte, two views
	logic                  reg_wr;                 // Qualified register write
	logic [2:0]            reg_sel;                // A14, A13, A0
	logic [BANK_IDX_W-1:0] bank_idx;               // Last bank select

	assign wdata   = prg_din_i;
	assign reg_wr  = ce_i && prg_write_i && prg_ain_i[15];
	assign reg_sel = {prg_ain_i[14:13], prg_ain_i[0]};

	// IRQ commands go straight to the counter in the write cycle
	assign irq_data_o     = prg_din_i;
	assign irq_latch_wr_o = reg_wr && (reg_sel == 3'b100); // $C000
	assign irq_reload_o   = reg_wr && (reg_sel == 3'b101); // $C001
	assign irq_disable_o  = reg_wr && (reg_sel == 3'b110); // $E000
	assign irq_enable_o   = reg_wr && (reg_sel == 3'b111); // $E001

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bank_idx      <= '0;
			prg_mode_o    <= 1'b0;
			chr_invert_o  <= 1'b0;
			mirroring_o   <= 1'b0;
			ram_en_o      <= 1'b0;
			ram_wp_o      <= 1'b0;
			prg_bank6_o   <= '0;
			prg_bank7_o   <= '0;
			chr_bank_r0_o <= '0;
			chr_bank_r1_o <= '0;
			chr_bank_r2_o <= '0;
			chr_bank_r3_o <= '0;
			chr_bank_r4_o <= '0;
			chr_bank_r5_o <= '0;
		end else if (reg_wr) begin
			case (reg_sel)
				3'b000: begin                              // $8000 bank select
					chr_invert_o <= wdata.bank_select.chr_invert;
					prg_mode_o   <= wdata.bank_select.prg_mode;
					bank_idx     <= wdata.bank_select.bank_idx;
				end
				3'b001: begin                              // $8001 bank data
					case (bank_idx)
						REG_R0: chr_bank_r0_o <= {prg_din_i[7:1], 1'b0}; // 2 KB aligned
						REG_R1: chr_bank_r1_o <= {prg_din_i[7:1], 1'b0}; // 2 KB aligned
						REG_R2: chr_bank_r2_o <= prg_din_i;
						REG_R3: chr_bank_r3_o <= prg_din_i;
						REG_R4: chr_bank_r4_o <= prg_din_i;
						REG_R5: chr_bank_r5_o <= prg_din_i;
						REG_R6: prg_bank6_o   <= prg_din_i[PRG_BANK_W-1:0];
						REG_R7: prg_bank7_o   <= prg_din_i[PRG_BANK_W-1:0];
						default: ;
					endcase
				end
				3'b010: mirroring_o <= prg_din_i[0];           // $A000
				3'b011: begin                              // $A001 RAM control
					ram_en_o <= wdata.ram_ctrl.ram_en;
					ram_wp_o <= wdata.ram_ctrl.ram_wp;
				end
				default: ;                                 // IRQ writes handled above
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== mmc3_prg_map.sv ====
/* MMC3 PRG mapping */

`timescale 1ns/1ps
`default_nettype none

module mmc3_prg_map
	import cart_bus_pkg::*;
	import mmc3_regs_pkg::*;
(
	input  wire [CPU_ADDR_W-1:0]  prg_ain_i,
	input  wire                   prg_write_i,
	input  wire [PRG_BANK_W-1:0]  prg_bank6_i,
	input  wire [PRG_BANK_W-1:0]  prg_bank7_i,
	input  wire                   prg_mode_i,
	input  wire                   ram_en_i,
	input  wire                   ram_wp_i,
	output logic [MEM_ADDR_W-1:0] prg_aout_o,
	output logic                  prg_allow_o
);

	logic [PRG_BANK_W-1:0] prg_sel;                // 8 KB bank for this slot
	logic                  ram_hit;

	// Slot select from A14..A13 and PRG mode
	always_comb begin
		case ({prg_ain_i[14:13], prg_mode_i})
			3'b00_0: prg_sel = prg_bank6_i;            // $8000 R6
			3'b00_1: prg_sel = PRG_BANK_SECOND_LAST;   // $8000 fixed
			3'b01_0: prg_sel = prg_bank7_i;            // $A000 R7 either mode
			3'b01_1: prg_sel = prg_bank7_i;
			3'b10_0: prg_sel = PRG_BANK_SECOND_LAST;   // $C000 fixed
			3'b10_1: prg_sel = prg_bank6_i;            // $C000 R6
			default: prg_sel = PRG_BANK_LAST;          // $E000 always last
		endcase
	end

	// $6000-$7FFF, write blocked when protected
	assign ram_hit = (prg_ain_i[15:13] == RAM_REGION) && ram_en_i
		&& !(ram_wp_i && prg_write_i);

	assign prg_aout_o = ram_hit ? {PRG_RAM_PREFIX, prg_ain_i[PRG_PAGE_W-1:0]}
		: {3'b000, prg_sel, prg_ain_i[PRG_PAGE_W-1:0]};

	assign prg_allow_o = (prg_ain_i[15] && !prg_write_i) || ram_hit; // ROM is read only

endmodule

`default_nettype wire

// ==== mmc3_chr_map.sv ====
/* MMC3 CHR mapping */

`timescale 1ns/1ps
`default_nettype none

module mmc3_chr_map
	import cart_bus_pkg::*;
	import mmc3_regs_pkg::*;
(
	input  wire [PPU_ADDR_W-1:0]  chr_ain_i,
	input  wire                   chr_ram_i,       // Cart has CHR RAM
	input  wire [CHR_BANK_W-1:0]  chr_bank_r0_i,
	input  wire [CHR_BANK_W-1:0]  chr_bank_r1_i,
	input  wire [CHR_BANK_W-1:0]  chr_bank_r2_i,
	input  wire [CHR_BANK_W-1:0]  chr_bank_r3_i,
	input  wire [CHR_BANK_W-1:0]  chr_bank_r4_i,
	input  wire [CHR_BANK_W-1:0]  chr_bank_r5_i,
	input  wire                   chr_invert_i,
	input  wire                   mirroring_i,
	output logic [MEM_ADDR_W-1:0] chr_aout_o,
	output logic                  chr_allow_o,
	output logic                  vram_a10_o,
	output logic                  vram_ce_o
);

	logic                  a12_sel;                // A12 after inversion
	logic [CHR_BANK_W-1:0] chr_sel;                // 1 KB bank

	assign a12_sel = chr_ain_i[12] ^ chr_invert_i;

	always_comb begin
		case ({a12_sel, chr_ain_i[11:10]})
			3'b000, 3'b001: chr_sel = {chr_bank_r0_i[7:1], chr_ain_i[10]}; // 2 KB pages
			3'b010, 3'b011: chr_sel = {chr_bank_r1_i[7:1], chr_ain_i[10]};
			3'b100:         chr_sel = chr_bank_r2_i;
			3'b101:         chr_sel = chr_bank_r3_i;
			3'b110:         chr_sel = chr_bank_r4_i;
			default:        chr_sel = chr_bank_r5_i;
		endcase
	end

	assign chr_aout_o  = {CHR_ROM_PREFIX, chr_sel, chr_ain_i[CHR_PAGE_W-1:0]};
	assign chr_allow_o = chr_ram_i;                                  // Writes only to RAM
	assign vram_a10_o  = mirroring_i ? chr_ain_i[11] : chr_ain_i[10]; // H or V mirroring
	assign vram_ce_o   = chr_ain_i[13];                              // $2000 and up is CIRAM

endmodule

`default_nettype wire

// ==== mmc3_irq_counter.sv ====
/* MMC3 scanline IRQ */

`timescale 1ns/1ps
`default_nettype none

module mmc3_irq_counter
	import cart_bus_pkg::*;
	import mmc3_regs_pkg::*;
(
	input  wire                  clk,
	input  wire                  rst_n_i,
	input  wire                  ce_i,
	input  wire [PPU_ADDR_W-1:0] chr_ain_i,
	input  wire [7:0]            irq_data_i,
	input  wire                  irq_latch_wr_i,
	input  wire                  irq_reload_i,
	input  wire                  irq_disable_i,
	input  wire                  irq_enable_i,
	output logic                 irq_o
);

	logic [3:0] cooldown;                          // CPU cycles since A12 fell
	logic [7:0] irq_latch;
	logic [7:0] counter;
	logic [7:0] next_count;
	logic       reload_pend;
	logic       irq_en;
	logic       a12_edge;                          // Filtered rising edge

	assign a12_edge   = ce_i && chr_ain_i[12] && (cooldown == 4'd0);
	assign next_count = ((counter == 8'd0) || reload_pend) ? irq_latch : counter - 8'd1;

	// Sprite fetches toggle A12 fast, so only a long low time arms the edge
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cooldown <= 4'd0;
		end else if (ce_i) begin
			if (chr_ain_i[12])
				cooldown <= A12_COOLDOWN;
			else if (cooldown != 4'd0)
				cooldown <= cooldown - 4'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			irq_latch   <= 8'd0;
			counter     <= 8'd0;
			reload_pend <= 1'b0;
			irq_en      <= 1'b0;
			irq_o       <= 1'b0;
		end else begin
			if (a12_edge) begin
				counter     <= next_count;
				reload_pend <= 1'b0;
				if ((next_count == 8'd0) && irq_en)
					irq_o <= 1'b1;                       // New behavior, fires at zero
			end
			if (irq_latch_wr_i)
				irq_latch <= irq_data_i;
			if (irq_reload_i)
				reload_pend <= 1'b1;                     // Wins over same cycle edge
			if (irq_disable_i) begin
				irq_en <= 1'b0;
				irq_o  <= 1'b0;                          // Acknowledge
			end
			if (irq_enable_i)
				irq_en <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== mmc3_mapper.sv ====
/* MMC3 mapper top */

`timescale 1ns/1ps
`default_nettype none

module mmc3_mapper
	import cart_bus_pkg::*;
	import mmc3_regs_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire                   ce_i,            // M2 strobe
	input  wire [CPU_ADDR_W-1:0]  prg_ain_i,
	input  wire                   prg_write_i,
	input  wire [7:0]             prg_din_i,
	input  wire [PPU_ADDR_W-1:0]  chr_ain_i,
	input  wire                   chr_ram_i,
	output logic [MEM_ADDR_W-1:0] prg_aout_o,
	output logic                  prg_allow_o,
	output logic [MEM_ADDR_W-1:0] chr_aout_o,
	output logic                  chr_allow_o,
	output logic                  vram_a10_o,
	output logic                  vram_ce_o,
	output logic                  irq_o
);

	logic [PRG_BANK_W-1:0] prg_bank6, prg_bank7;
	logic [CHR_BANK_W-1:0] chr_bank_r0, chr_bank_r1, chr_bank_r2;
	logic [CHR_BANK_W-1:0] chr_bank_r3, chr_bank_r4, chr_bank_r5;
	logic                  prg_mode, chr_invert, mirroring, ram_en, ram_wp;
	logic [7:0]            irq_data;
	logic                  irq_latch_wr, irq_reload, irq_disable, irq_enable;

	mmc3_reg_ctrl i_mmc3_reg_ctrl (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.ce_i           (ce_i),
		.prg_ain_i      (prg_ain_i),
		.prg_write_i    (prg_write_i),
		.prg_din_i      (prg_din_i),
		.prg_bank6_o    (prg_bank6),
		.prg_bank7_o    (prg_bank7),
		.chr_bank_r0_o  (chr_bank_r0),
		.chr_bank_r1_o  (chr_bank_r1),
		.chr_bank_r2_o  (chr_bank_r2),
		.chr_bank_r3_o  (chr_bank_r3),
		.chr_bank_r4_o  (chr_bank_r4),
		.chr_bank_r5_o  (chr_bank_r5),
		.prg_mode_o     (prg_mode),
		.chr_invert_o   (chr_invert),
		.mirroring_o    (mirroring),
		.ram_en_o       (ram_en),
		.ram_wp_o       (ram_wp),
		.irq_data_o     (irq_data),
		.irq_latch_wr_o (irq_latch_wr),
		.irq_reload_o   (irq_reload),
		.irq_disable_o  (irq_disable),
		.irq_enable_o   (irq_enable)
	);

	mmc3_prg_map i_mmc3_prg_map (
		.prg_ain_i   (prg_ain_i),
		.prg_write_i (prg_write_i),
		.prg_bank6_i (prg_bank6),
		.prg_bank7_i (prg_bank7),
		.prg_mode_i  (prg_mode),
		.ram_en_i    (ram_en),
		.ram_wp_i    (ram_wp),
		.prg_aout_o  (prg_aout_o),
		.prg_allow_o (prg_allow_o)
	);

	mmc3_chr_map i_mmc3_chr_map (
		.chr_ain_i     (chr_ain_i),
		.chr_ram_i     (chr_ram_i),
		.chr_bank_r0_i (chr_bank_r0),
		.chr_bank_r1_i (chr_bank_r1),
		.chr_bank_r2_i (chr_bank_r2),
		.chr_bank_r3_i (chr_bank_r3),
		.chr_bank_r4_i (chr_bank_r4),
		.chr_bank_r5_i (chr_bank_r5),
		.chr_invert_i  (chr_invert),
		.mirroring_i   (mirroring),
		.chr_aout_o    (chr_aout_o),
		.chr_allow_o   (chr_allow_o),
		.vram_a10_o    (vram_a10_o),
		.vram_ce_o     (vram_ce_o)
	);

	mmc3_irq_counter i_mmc3_irq_counter (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.ce_i           (ce_i),
		.chr_ain_i      (chr_ain_i),
		.irq_data_i     (irq_data),
		.irq_latch_wr_i (irq_latch_wr),
		.irq_reload_i   (irq_reload),
		.irq_disable_i  (irq_disable),
		.irq_enable_i   (irq_enable),
		.irq_o          (irq_o)
	);

endmodule

`default_nettype wire

// ==== tb_mmc3_mapper.sv ====
/* MMC3 mapper testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_mmc3_mapper;

	localparam int MAX_REC = 64;                   // Pattern file capacity

	logic        clk;
	logic        rst_n_i;
	logic        ce_i;
	logic [15:0] prg_ain_i;
	logic        prg_write_i;
	logic [7:0]  prg_din_i;
	logic [13:0] chr_ain_i;
	logic        chr_ram_i;
	wire  [21:0] prg_aout_o;
	wire         prg_allow_o;
	wire  [21:0] chr_aout_o;
	wire         chr_allow_o;
	wire         vram_a10_o;
	wire         vram_ce_o;
	wire         irq_o;

	logic [31:0] pat_mem [0:4*MAX_REC-1];          // Four words per record
	int          rec_count = 0;
	int          checks    = 0;
	int          errors    = 0;
	logic        loaded    = 1'b0;                 // Arms the watchdog
	logic [31:0] rnd_state = 32'he6e0_65b6;

	mmc3_mapper i_mmc3_mapper (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ce_i        (ce_i),
		.prg_ain_i   (prg_ain_i),
		.prg_write_i (prg_write_i),
		.prg_din_i   (prg_din_i),
		.chr_ain_i   (chr_ain_i),
		.chr_ram_i   (chr_ram_i),
		.prg_aout_o  (prg_aout_o),
		.prg_allow_o (prg_allow_o),
		.chr_aout_o  (chr_aout_o),
		.chr_allow_o (chr_allow_o),
		.vram_a10_o  (vram_a10_o),
		.vram_ce_o   (vram_ce_o),
		.irq_o       (irq_o)
	);

	always #10 clk = ~clk;                         // 20 ns period

	always @(posedge clk)
		ce_i <= ~ce_i;                             // CPU cycle every second clock

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Hold the write until the DUT sees it on a ce_i edge
	task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		prg_ain_i   <= addr;
		prg_din_i   <= data;
		prg_write_i <= 1'b1;
		do
			@(posedge clk);
		while (!ce_i);
		prg_write_i <= 1'b0;
	endtask

	task automatic check_prg(input logic [15:0] addr, input logic wr, input logic [31:0] exp);
		@(posedge clk);
		prg_ain_i   <= addr;
		prg_write_i <= wr;
		@(negedge clk);                            // Outputs settled
		checks++;
		if (prg_aout_o !== exp[21:0] || prg_allow_o !== exp[24]) begin
			errors++;
			$display("Error at %0d ns: PRG %h wr %b gave %h allow %b, expected %h allow %b",
				$time, addr, wr, prg_aout_o, prg_allow_o, exp[21:0], exp[24]);
		end
		@(posedge clk);
		prg_write_i <= 1'b0;
	endtask

	task automatic check_chr(input logic [13:0] addr, input logic a10, input logic [31:0] exp);
		logic [9:0]  low;
		logic [21:0] want;
		logic        ram_flag;
		rnd_state = xorshift(rnd_state);
		low       = rnd_state[9:0];                // Offset inside the 1 KB page
		want      = exp[21:0] | {12'b0, low};
		ram_flag  = ~chr_ram_i;                    // Alternate CHR RAM and ROM carts
		@(posedge clk);
		chr_ain_i <= addr | {4'b0, low};
		chr_ram_i <= ram_flag;
		@(negedge clk);
		checks++;
		if (chr_aout_o !== want || vram_a10_o !== a10) begin
			errors++;
			$display("Error at %0d ns: CHR %h gave %h a10 %b, expected %h a10 %b",
				$time, addr | {4'b0, low}, chr_aout_o, vram_a10_o, want, a10);
		end
		if (chr_allow_o !== ram_flag || vram_ce_o !== addr[13]) begin
			errors++;
			$display("Error at %0d ns: CHR %h gave allow %b ce %b, expected allow %b ce %b",
				$time, addr | {4'b0, low}, chr_allow_o, vram_ce_o, ram_flag, addr[13]);
		end
		@(posedge clk);
		chr_ain_i <= '0;
	endtask

	// One A12 pulse per line, low long enough to clear the filter
	task automatic run_scanlines(input logic [7:0] n, input logic exp_irq);
		repeat (n) begin
			@(posedge clk);
			chr_ain_i <= 14'h1000;
			repeat (4) @(posedge clk);
			chr_ain_i <= 14'h0000;
			repeat (40) @(posedge clk);
		end
		@(negedge clk);
		checks++;
		if (irq_o !== exp_irq) begin
			errors++;
			$display("Error at %0d ns: irq_o %b after %0d scanlines, expected %b",
				$time, irq_o, n, exp_irq);
		end
	endtask

	initial begin
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
		clk         = 1'b0;
		rst_n_i     = 1'b0;
		ce_i        = 1'b0;
		prg_ain_i   = '0;
		prg_write_i = 1'b0;
		prg_din_i   = '0;
		chr_ain_i   = '0;
		chr_ram_i   = 1'b0;
		$readmemh("mmc3_patterns.txt", pat_mem);
		while (rec_count < MAX_REC && pat_mem[4*rec_count] >= 32'd1
			&& pat_mem[4*rec_count] <= 32'd4)
			rec_count++;                           // Stops at first empty slot
		loaded = 1'b1;
		if (rec_count == 0) begin
			errors++;
			$display("No pattern records could be loaded from mmc3_patterns.txt");
		end
		repeat (16) @(posedge clk);
		rst_n_i <= 1'b1;
		for (int i = 0; i < rec_count; i++) begin
			op   = pat_mem[4*i];
			addr = pat_mem[4*i+1];
			data = pat_mem[4*i+2];
			exp  = pat_mem[4*i+3];
			case (op[3:0])
				4'h1:    write_reg(addr[15:0], data[7:0]);
				4'h2:    check_prg(addr[15:0], data[0], exp);
				4'h3:    check_chr(addr[13:0], data[0], exp);
				4'h4:    run_scanlines(data[7:0], exp[0]);
				default: ;
			endcase
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		wait (loaded);
		repeat ((rec_count + 1) * 400) @(posedge clk);  // Budget per record
		$display("Timeout, the pattern run did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mmc3_patterns.txt ====
// op addr data expect, op 1 write, 2 CPU access, 3 PPU access, 4 scanlines
// CPU: data is write flag, expect bit 24 allow and bits 21..0 address; PPU: data is A10
4 0000 00 00000000
2 8000 00 01000000
2 E000 00 0107E000
1 8000 06 00000000
1 8001 05 00000000
1 8000 07 00000000
1 8001 CA 00000000
2 8000 00 0100A000
2 A123 00 01014123
2 C000 00 0107C000
1 8000 46 00000000
2 8000 00 0107C000
2 C010 00 0100A010
2 E000 00 0107E000
1 8000 00 00000000
1 8001 11 00000000
1 8000 01 00000000
1 8001 21 00000000
1 8000 02 00000000
1 8001 33 00000000
1 8000 03 00000000
1 8001 44 00000000
1 8000 04 00000000
1 8001 55 00000000
1 8000 05 00000000
1 8001 66 00000000
3 0000 00 00204000
3 0400 01 00204400
3 0C00 01 00208400
3 1000 00 0020CC00
3 1C00 01 00219800
1 8000 80 00000000
3 1400 01 00204400
3 0400 01 00211000
3 0800 00 00215400
1 A000 01 00000000
3 2800 01 00215400
3 2400 00 00211000
2 6000 00 0007E000
1 A001 80 00000000
2 6123 00 013C0123
2 6123 01 013C0123
1 A001 C0 00000000
2 6123 00 013C0123
2 6123 01 0007E123
4 0000 01 00000000
1 C000 03 00000000
1 C001 00 00000000
1 E001 00 00000000
4 0000 03 00000000
4 0000 01 00000001
1 E000 00 00000000
4 0000 00 00000000
4 0000 04 00000000

// ==== build.f ====
cart_bus_pkg.sv
mmc3_regs_pkg.sv
mmc3_reg_ctrl.sv
mmc3_prg_map.sv
mmc3_chr_map.sv
mmc3_irq_counter.sv
mmc3_mapper.sv
tb_mmc3_mapper.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mmc3_mapper
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
